/* Bender.yml */
package:
  name: feature_extractor

sources:
  - feature_pkg.sv
  - window_buffer.sv
  - mean_std.sv
  - amplitude_stats.sv
  - feature_frame.sv
  - feature_extractor_top.sv
  - target: test
    files:
      - tb_feature_extractor.sv

/* amplitude_stats.sv */
`timescale 1ns/100ps
`default_nettype none

module amplitude_stats (
    input  logic                  clk,
    input  logic                  rst,
    input  feature_pkg::sample_t  window [feature_pkg::window_len],
    input  logic                  window_valid,
    output feature_pkg::feature_t min_value,
    output feature_pkg::feature_t max_value,
    output feature_pkg::feature_t range_value
);

    import feature_pkg::*;

    // Per-half extremes of the incoming window
    sample_t lo_min_next;
    sample_t lo_max_next;
    sample_t hi_min_next;
    sample_t hi_max_next;

    sample_t lo_min_s1;
    sample_t lo_max_s1;
    sample_t hi_min_s1;
    sample_t hi_max_s1;
    logic    valid_s1;

    sample_t min_s2;
    sample_t max_s2;
    logic    valid_s2;

    // Two independent compare trees of half_len entries each
    always_comb begin
        lo_min_next = window[0];
        lo_max_next = window[0];
        hi_min_next = window[half_len];
        hi_max_next = window[half_len];
        for (int i = 1; i < half_len; i++) begin
            if (window[i] < lo_min_next) begin
                lo_min_next = window[i];
            end
            if (window[i] > lo_max_next) begin
                lo_max_next = window[i];
            end
            if (window[half_len + i] < hi_min_next) begin
                hi_min_next = window[half_len + i];
            end
            if (window[half_len + i] > hi_max_next) begin
                hi_max_next = window[half_len + i];
            end
        end
    end

    // Stage enables, same depth as mean_std
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= window_valid;
            valid_s2 <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (window_valid) begin
            lo_min_s1 <= lo_min_next;
            lo_max_s1 <= lo_max_next;
            hi_min_s1 <= hi_min_next;
            hi_max_s1 <= hi_max_next;
        end
        // Merge the halves
        if (valid_s1) begin
            min_s2 <= (lo_min_s1 < hi_min_s1) ? lo_min_s1 : hi_min_s1;
            max_s2 <= (lo_max_s1 > hi_max_s1) ? lo_max_s1 : hi_max_s1;
        end
        if (valid_s2) begin
            min_value   <= min_s2;
            max_value   <= max_s2;
            range_value <= max_s2 - min_s2;
        end
    end

endmodule

`default_nettype wire

/* feature_extractor_top.sv */
`timescale 1ns/100ps
`default_nettype none

module feature_extractor_top (
    input  logic                  clk,
    input  logic                  rst,
    input  feature_pkg::sample_t  sample,
    input  logic                  sample_valid,
    output feature_pkg::feature_t features [feature_pkg::feature_count],
    output logic                  features_valid,
    output feature_pkg::count_t   window_count
);

    import feature_pkg::*;

    sample_t  window [window_len];
    logic     window_valid;

    feature_t mean;
    feature_t stddev;
    feature_t above_count;
    logic     stats_valid;

    feature_t min_value;
    feature_t max_value;
    feature_t range_value;

    window_buffer window_buffer_inst (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .sample_valid (sample_valid),
        .window       (window),
        .window_valid (window_valid)
    );

    // Both stat pipelines are three stages deep
    mean_std mean_std_inst (
        .clk          (clk),
        .rst          (rst),
        .window       (window),
        .window_valid (window_valid),
        .mean         (mean),
        .stddev       (stddev),
        .above_count  (above_count),
        .stats_valid  (stats_valid)
    );

    amplitude_stats amplitude_stats_inst (
        .clk          (clk),
        .rst          (rst),
        .window       (window),
        .window_valid (window_valid),
        .min_value    (min_value),
        .max_value    (max_value),
        .range_value  (range_value)
    );

    feature_frame feature_frame_inst (
        .clk            (clk),
        .rst            (rst),
        .mean           (mean),
        .stddev         (stddev),
        .above_count    (above_count),
        .min_value      (min_value),
        .max_value      (max_value),
        .range_value    (range_value),
        .stats_valid    (stats_valid),
        .features       (features),
        .features_valid (features_valid),
        .window_count   (window_count)
    );

endmodule

`default_nettype wire

/* feature_frame.sv */
`timescale 1ns/100ps
`default_nettype none

module feature_frame (
    input  logic                  clk,
    input  logic                  rst,
    input  feature_pkg::feature_t mean,
    input  feature_pkg::feature_t stddev,
    input  feature_pkg::feature_t above_count,
    input  feature_pkg::feature_t min_value,
    input  feature_pkg::feature_t max_value,
    input  feature_pkg::feature_t range_value,
    input  logic                  stats_valid,
    output feature_pkg::feature_t features [feature_pkg::feature_count],
    output logic                  features_valid,
    output feature_pkg::count_t   window_count
);

    import feature_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < feature_count; i++) begin
                features[i] <= '0;
            end
            features_valid <= 1'b0;
            window_count   <= '0;
        end else begin
            features_valid <= stats_valid;
            if (stats_valid) begin
                features[feat_mean]   <= mean;
                features[feat_stddev] <= stddev;
                features[feat_min]    <= min_value;
                features[feat_max]    <= max_value;
                features[feat_range]  <= range_value;
                features[feat_above]  <= above_count;
                // Counter wraps, first frame reads 1
                window_count <= window_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* feature_pkg.sv */
`default_nettype none

package feature_pkg;

    // Window geometry
    localparam int window_len    = 40;
    localparam int half_len      = window_len / 2;
    localparam int feature_count = 6;

    // Data widths
    localparam int sample_width  = 16;
    localparam int feature_width = 16;
    localparam int sum_width     = 32;
    localparam int acc_width     = 40;
    localparam int var_width     = 32;
    localparam int count_width   = 16;
    localparam int idx_width     = 6;

    // Slot of each feature in the output vector
    localparam int feat_mean   = 0;
    localparam int feat_stddev = 1;
    localparam int feat_min    = 2;
    localparam int feat_max    = 3;
    localparam int feat_range  = 4;
    localparam int feat_above  = 5;

    typedef logic [sample_width-1:0]  sample_t;
    typedef logic [feature_width-1:0] feature_t;

    // Sum of 40 samples needs 22 bits, kept at 32
    typedef logic [sum_width-1:0]     sum_t;

    // Sum of 40 squared deviations reaches about 2^37.3
    typedef logic [acc_width-1:0]     acc_t;

    typedef logic [var_width-1:0]     var_t;
    typedef logic [count_width-1:0]   count_t;
    typedef logic [idx_width-1:0]     idx_t;

endpackage

`default_nettype wire

/* list.f */
feature_pkg.sv
window_buffer.sv
mean_std.sv
amplitude_stats.sv
feature_frame.sv
feature_extractor_top.sv
tb_feature_extractor.sv

/* mean_std.sv */
`timescale 1ns/100ps
`default_nettype none

module mean_std (
    input  logic                  clk,
    input  logic                  rst,
    input  feature_pkg::sample_t  window [feature_pkg::window_len],
    input  logic                  window_valid,
    output feature_pkg::feature_t mean,
    output feature_pkg::feature_t stddev,
    output feature_pkg::feature_t above_count,
    output logic                  stats_valid
);

    import feature_pkg::*;

    // Stage 1 signals
    sum_t     sum_next;
    sum_t     sum_s1;
    sample_t  window_s1 [window_len];
    logic     valid_s1;

    // Stage 2 signals
    feature_t mean_next;
    acc_t     acc_next;
    feature_t above_next;
    acc_t     acc_s2;
    feature_t mean_s2;
    feature_t above_s2;
    logic     valid_s2;

    // Stage 3 signals
    var_t     var_next;
    feature_t root_next;

    // Restoring square root, one result bit per step, rounds down
    function automatic feature_t isqrt(input var_t value);
        logic [19:0] rem;
        logic [19:0] trial;
        feature_t    root;
        rem  = '0;
        root = '0;
        for (int i = 15; i >= 0; i--) begin
            // Bring down the next pair of radicand bits
            rem   = {rem[17:0], value[2*i+1 -: 2]};
            trial = {2'b00, root, 2'b01};
            if (rem >= trial) begin
                rem  = rem - trial;
                root = {root[14:0], 1'b1};
            end else begin
                root = {root[14:0], 1'b0};
            end
        end
        return root;
    endfunction

    // Sum of the incoming window
    always_comb begin
        sum_next = '0;
        for (int i = 0; i < window_len; i++) begin
            sum_next = sum_next + sum_t'(window[i]);
        end
    end

    // Mean, squared deviations and count above the mean
    always_comb begin
        sample_t diff;
        var_t    sq;
        mean_next  = feature_t'(sum_s1 / window_len);
        acc_next   = '0;
        above_next = '0;
        for (int i = 0; i < window_len; i++) begin
            if (window_s1[i] > mean_next) begin
                diff       = window_s1[i] - mean_next;
                above_next = above_next + 1'b1;
            end else begin
                diff = mean_next - window_s1[i];
            end
            sq       = diff * diff;
            acc_next = acc_next + acc_t'(sq);
        end
    end

    // Variance and its root
    assign var_next  = var_t'(acc_s2 / window_len);
    assign root_next = isqrt(var_next);

    // Valid bit travelling with the data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_s1    <= 1'b0;
            valid_s2    <= 1'b0;
            stats_valid <= 1'b0;
        end else begin
            valid_s1    <= window_valid;
            valid_s2    <= valid_s1;
            stats_valid <= valid_s2;
        end
    end

    // Payload, loaded only when its stage holds a window
    always_ff @(posedge clk) begin
        if (window_valid) begin
            sum_s1    <= sum_next;
            window_s1 <= window;
        end
        if (valid_s1) begin
            acc_s2   <= acc_next;
            mean_s2  <= mean_next;
            above_s2 <= above_next;
        end
        if (valid_s2) begin
            mean        <= mean_s2;
            stddev      <= root_next;
            above_count <= above_s2;
        end
    end

endmodule

`default_nettype wire

/* tb_feature_extractor.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_feature_extractor;

    import feature_pkg::*;

    localparam int clk_period       = 40;
    localparam int directed_windows = 4;
    localparam int random_windows   = 50;
    localparam int burst_windows    = 5;
    localparam int total_samples    =
        (directed_windows + random_windows + burst_windows) * window_len;
    localparam int timeout_cycles   = total_samples * 3 + 200;

    logic     clk;
    logic     rst;
    sample_t  sample;
    logic     sample_valid;
    feature_t features [feature_count];
    logic     features_valid;
    count_t   window_count;

    // Reference model state
    int          win_model [window_len];
    int          fill_model;
    logic [4:0]  due;
    feature_t    exp_q [$];
    count_t      exp_count;
    feature_t    last_frame [feature_count];
    logic [31:0] rng_state;

    feature_extractor_top feature_extractor_top_inst (
        .clk            (clk),
        .rst            (rst),
        .sample         (sample),
        .sample_valid   (sample_valid),
        .features       (features),
        .features_valid (features_valid),
        .window_count   (window_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first failure");
    endtask

    task automatic fail_value(input string name, input int expected, input int actual);
        $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        stop_run();
    endtask

    task automatic expect_value(input string name, input int expected, input int actual);
        assert (expected == actual) else fail_value(name, expected, actual);
    endtask

    function automatic string feature_name(input int slot);
        case (slot)
            feat_mean:   return "mean";
            feat_stddev: return "stddev";
            feat_min:    return "min";
            feat_max:    return "max";
            feat_range:  return "range";
            default:     return "above_count";
        endcase
    endfunction

    function automatic sample_t lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    // Expected features of the window held in win_model
    task automatic model_window();
        longint sum;
        longint ssd;
        longint dev;
        longint var_value;
        int     mean_value;
        int     root;
        int     cand;
        int     lo;
        int     hi;
        int     above;
        sum = 0;
        for (int i = 0; i < window_len; i++) begin
            sum = sum + win_model[i];
        end
        mean_value = int'(sum / window_len);
        ssd   = 0;
        above = 0;
        lo    = win_model[0];
        hi    = win_model[0];
        for (int i = 0; i < window_len; i++) begin
            dev = longint'(win_model[i]) - mean_value;
            ssd = ssd + dev * dev;
            if (win_model[i] > mean_value) above++;
            if (win_model[i] < lo) lo = win_model[i];
            if (win_model[i] > hi) hi = win_model[i];
        end
        var_value = ssd / window_len;
        // Largest root whose square stays within the variance
        root = 0;
        for (int b = 15; b >= 0; b--) begin
            cand = root | (1 << b);
            if (longint'(cand) * cand <= var_value) root = cand;
        end
        exp_q.push_back(feature_t'(mean_value));
        exp_q.push_back(feature_t'(root));
        exp_q.push_back(feature_t'(lo));
        exp_q.push_back(feature_t'(hi));
        exp_q.push_back(feature_t'(hi - lo));
        exp_q.push_back(feature_t'(above));
    endtask

    // Input monitor sampling inputs settled 2 ns after the previous edge
    always @(posedge clk) begin
        logic took_last;
        took_last = 1'b0;
        if (!rst && sample_valid) begin
            win_model[fill_model] = int'(sample);
            if (fill_model == window_len - 1) begin
                fill_model = 0;
                model_window();
                took_last = 1'b1;
            end else begin
                fill_model++;
            end
        end
        // Frame is due 4 edges after the closing sample
        due <= {due[3:0], took_last};
    end

    // Output checks mid-cycle
    always @(negedge clk) begin
        feature_t expected;
        if (!rst) begin
            assert (features_valid == due[4])
                else fail_value("features_valid", due[4], features_valid);
            if (features_valid) begin
                exp_count = exp_count + 1'b1;
                for (int i = 0; i < feature_count; i++) begin
                    expected      = exp_q.pop_front();
                    last_frame[i] = features[i];
                    expect_value(feature_name(i), expected, features[i]);
                end
            end
            expect_value("window_count", exp_count, window_count);
        end
    end

    task automatic drive_sample(input sample_t value);
        sample       = value;
        sample_valid = 1'b1;
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int cycles);
        sample_valid = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || due != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_frame(input int m, input int s, input int lo, input int hi,
                               input int r, input int above);
        expect_value("mean", m, last_frame[feat_mean]);
        expect_value("stddev", s, last_frame[feat_stddev]);
        expect_value("min", lo, last_frame[feat_min]);
        expect_value("max", hi, last_frame[feat_max]);
        expect_value("range", r, last_frame[feat_range]);
        expect_value("above_count", above, last_frame[feat_above]);
    endtask

    initial begin
        #(timeout_cycles * clk_period);
        $display("Timeout after %0d cycles, outputs stopped arriving", timeout_cycles);
        stop_run();
    end

    initial begin
        rst          = 1'b1;
        sample       = '0;
        sample_valid = 1'b0;
        fill_model   = 0;
        due          = '0;
        exp_count    = '0;
        rng_state    = 32'd33;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // Quiet period with no frame and a zero count
        idle(20);

        // Flat window
        for (int i = 0; i < window_len; i++) drive_sample(16'd1234);
        idle(0);
        wait_drained();
        check_frame(1234, 0, 1234, 1234, 0, 0);

        // Alternating 0 and 200
        for (int i = 0; i < window_len; i++) drive_sample((i % 2) ? 16'd200 : 16'd0);
        idle(0);
        wait_drained();
        check_frame(100, 100, 0, 200, 200, 20);

        // Ramp 0 to 39
        for (int i = 0; i < window_len; i++) drive_sample(sample_t'(i));
        idle(0);
        wait_drained();
        check_frame(19, 11, 0, 39, 39, 20);

        // Full-scale split giving the largest squared deviations
        for (int i = 0; i < window_len; i++) drive_sample((i < 20) ? 16'd0 : 16'hffff);
        idle(0);
        wait_drained();
        check_frame(32767, 32767, 0, 65535, 65535, 20);

        // Random windows with gaps of up to two idle cycles
        for (int w = 0; w < random_windows; w++) begin
            for (int i = 0; i < window_len; i++) begin
                drive_sample(lcg_next());
                idle(int'(lcg_next() % 3));
            end
        end
        wait_drained();

        // sample_valid held high across several windows
        for (int i = 0; i < burst_windows * window_len; i++) drive_sample(lcg_next());
        idle(0);
        wait_drained();
        idle(10);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* window_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module window_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  feature_pkg::sample_t sample,
    input  logic                 sample_valid,
    output feature_pkg::sample_t window [feature_pkg::window_len],
    output logic                 window_valid
);

    import feature_pkg::*;

    idx_t fill_idx;
    logic last_sample;

    // High while the next strobed sample closes the window
    assign last_sample = (fill_idx == idx_t'(window_len - 1));

    // Sample storage, written at the fill index
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            window[fill_idx] <= sample;
        end
    end

    // Fill index and window strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_idx     <= '0;
            window_valid <= 1'b0;
        end else begin
            // Last entry lands on the same edge, so the window is whole with the strobe
            window_valid <= sample_valid && last_sample;
            if (sample_valid) begin
                if (last_sample) begin
                    fill_idx <= '0;
                end else begin
                    fill_idx <= fill_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire
